// ==== mm_pkg.sv ====
// Shared matrix sizes, Q8.8 formats and scratchpad layout, imported by every accelerator block
package mm_pkg;

    localparam int ELEM_W = 16; // Q8.8 element
    localparam int FRAC_W = 8;
    localparam int LANES  = 4;  // Elements per word
    localparam int WORD_W = ELEM_W * LANES;

    localparam int I_ROWS = 4;
    localparam int W_ROWS = 4;  // Also the columns of C

    // Scratchpad map: I rows, then W rows, then C rows
    localparam int ADDR_W  = 4;
    localparam int IN_BASE = 0;
    localparam int W_BASE  = IN_BASE + I_ROWS;
    localparam int C_BASE  = W_BASE + W_ROWS;

    localparam int CNT_W = 4;   // Enough for a fill of up to 15 words

    // One scratchpad word, seen as a stream beat or as four elements
    typedef union packed {
        logic [WORD_W-1:0]             raw;
        logic [LANES-1:0][ELEM_W-1:0]  lanes; // Lane 0 in bits 15:0
    } sp_word_u;

endpackage

// ==== axis_fifo.sv ====
// Small synchronous stream FIFO with a last flag and fill count, used on all three stream ports
`timescale 1ns/1ps

module axis_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [mm_pkg::WORD_W-1:0] in_data,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic                      in_last,
    output logic [mm_pkg::WORD_W-1:0] out_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      out_last,
    output logic [mm_pkg::CNT_W-1:0]  fill
);
    import mm_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    logic [WORD_W-1:0] mem_data [DEPTH];
    logic              mem_last [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              live;     // Set one cycle after reset is released
    logic              push;
    logic              pop;

    assign in_ready  = live && (fill != CNT_W'(DEPTH));
    assign out_valid = (fill != '0);
    assign out_data  = mem_data[rd_ptr];
    assign out_last  = mem_last[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            live   <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            live <= 1'b1;
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

endmodule

// ==== shared_scratchpad.sv ====
// Operand and result memory shared by loader, engine and drainer through a fixed-priority arbiter
`timescale 1ns/1ps

module shared_scratchpad (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      ld_req,
    input  logic                      ld_we,
    input  logic [mm_pkg::ADDR_W-1:0] ld_addr,
    input  mm_pkg::sp_word_u          ld_wdata,
    output logic                      ld_gnt,
    output mm_pkg::sp_word_u          ld_rdata,
    input  logic                      en_req,
    input  logic                      en_we,
    input  logic [mm_pkg::ADDR_W-1:0] en_addr,
    input  mm_pkg::sp_word_u          en_wdata,
    output logic                      en_gnt,
    output mm_pkg::sp_word_u          en_rdata,
    input  logic                      dr_req,
    input  logic                      dr_we,
    input  logic [mm_pkg::ADDR_W-1:0] dr_addr,
    input  mm_pkg::sp_word_u          dr_wdata,
    output logic                      dr_gnt,
    output mm_pkg::sp_word_u          dr_rdata
);
    import mm_pkg::*;

    localparam int SP_WORDS = C_BASE + I_ROWS;

    sp_word_u          mem [SP_WORDS];
    sp_word_u          rdata_q;
    logic              sel_we;
    logic [ADDR_W-1:0] sel_addr;
    sp_word_u          sel_wdata;
    logic              any_gnt;

    // Drainer first, then engine, then loader
    assign dr_gnt  = dr_req;
    assign en_gnt  = en_req && !dr_req;
    assign ld_gnt  = ld_req && !dr_req && !en_req;
    assign any_gnt = dr_gnt || en_gnt || ld_gnt;

    always_comb
    begin
        sel_we    = ld_we;
        sel_addr  = ld_addr;
        sel_wdata = ld_wdata;
        if (dr_gnt)
        begin
            sel_we    = dr_we;
            sel_addr  = dr_addr;
            sel_wdata = dr_wdata;
        end
        else if (en_gnt)
        begin
            sel_we    = en_we;
            sel_addr  = en_addr;
            sel_wdata = en_wdata;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (any_gnt && sel_we)
            mem[sel_addr] <= sel_wdata;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            rdata_q <= '0;
        else if (any_gnt && !sel_we)
            rdata_q <= mem[sel_addr]; // Valid one cycle after the grant
    end

    // Only the peer granted last cycle samples this
    assign ld_rdata = rdata_q;
    assign en_rdata = rdata_q;
    assign dr_rdata = rdata_q;

endmodule

// ==== operand_loader.sv ====
// Copies four I rows and four W rows from the input FIFOs into the scratchpad on each load start
`timescale 1ns/1ps

module operand_loader (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      start,
    output logic                      done,
    input  logic [mm_pkg::WORD_W-1:0] i_data,
    input  logic                      i_valid,
    output logic                      i_ready,
    input  logic [mm_pkg::WORD_W-1:0] w_data,
    input  logic                      w_valid,
    output logic                      w_ready,
    output logic                      ld_req,
    output logic                      ld_we,
    output logic [mm_pkg::ADDR_W-1:0] ld_addr,
    output mm_pkg::sp_word_u          ld_wdata,
    input  logic                      ld_gnt
);
    import mm_pkg::*;

    localparam int LAST_BEAT = I_ROWS + W_ROWS - 1;
    localparam int BEAT_W    = $clog2(I_ROWS + W_ROWS);

    logic              busy;
    logic [BEAT_W-1:0] beat;    // Counts I rows first and then W rows
    logic              w_phase;

    assign w_phase = (beat >= BEAT_W'(I_ROWS));
    assign ld_req  = busy && (w_phase ? w_valid : i_valid);
    assign ld_we   = 1'b1;
    assign ld_addr = ADDR_W'(IN_BASE) + ADDR_W'(beat); // W rows follow the I rows

    // Pop only on the granted write
    assign i_ready = busy && !w_phase && ld_gnt;
    assign w_ready = busy && w_phase && ld_gnt;

    always_comb
    begin
        ld_wdata.raw = w_phase ? w_data : i_data;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            busy <= 1'b0;
            beat <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                beat <= '0;
            end
            else if (ld_gnt)
            begin
                if (beat == BEAT_W'(LAST_BEAT))
                begin
                    busy <= 1'b0;
                    done <= 1'b1; // All eight rows written
                end
                else
                    beat <= beat + 1'b1;
            end
        end
    end

endmodule

// ==== dot_product_engine.sv ====
// Computes C = I * W^T in Q8.8 from scratchpad rows and writes each packed C row back
`timescale 1ns/1ps

module dot_product_engine (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      start,
    output logic                      done,
    output logic                      en_req,
    output logic                      en_we,
    output logic [mm_pkg::ADDR_W-1:0] en_addr,
    output mm_pkg::sp_word_u          en_wdata,
    input  logic                      en_gnt,
    input  mm_pkg::sp_word_u          en_rdata
);
    import mm_pkg::*;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_RD_I   = 3'd1;
    localparam logic [2:0] S_WAIT_I = 3'd2;
    localparam logic [2:0] S_RD_W   = 3'd3;
    localparam logic [2:0] S_WAIT_W = 3'd4;
    localparam logic [2:0] S_WR_C   = 3'd5;

    localparam int ROW_W = $clog2(I_ROWS);
    localparam int COL_W = $clog2(W_ROWS);
    localparam int ACC_W = 2 * ELEM_W + $clog2(LANES);

    logic [2:0]              state;
    logic [ROW_W-1:0]        row;
    logic [COL_W-1:0]        col;
    sp_word_u                i_row;   // Cached I row
    sp_word_u                c_row;   // C row being built
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] scaled;

    // Full-width sum of the four lane products
    always_comb
    begin
        acc = '0;
        for (int k = 0; k < LANES; k++)
        begin
            acc = acc + $signed(i_row.lanes[k]) * $signed(en_rdata.lanes[k]);
        end
    end

    assign scaled = acc >>> FRAC_W; // Low 16 bits kept, wraps on overflow

    assign en_req   = (state == S_RD_I) || (state == S_RD_W) || (state == S_WR_C);
    assign en_we    = (state == S_WR_C);
    assign en_wdata = c_row;

    always_comb
    begin
        case (state)
            S_RD_I:  en_addr = ADDR_W'(IN_BASE) + ADDR_W'(row);
            S_WR_C:  en_addr = ADDR_W'(C_BASE) + ADDR_W'(row);
            default: en_addr = ADDR_W'(W_BASE) + ADDR_W'(col);
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state <= S_IDLE;
            row   <= '0;
            col   <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        state <= S_RD_I;
                        row   <= '0;
                        col   <= '0;
                    end
                end
                S_RD_I:   if (en_gnt) state <= S_WAIT_I;
                S_WAIT_I: state <= S_RD_W;
                S_RD_W:   if (en_gnt) state <= S_WAIT_W;
                S_WAIT_W:
                begin
                    if (col == COL_W'(W_ROWS - 1))
                        state <= S_WR_C;
                    else
                    begin
                        col   <= col + 1'b1;
                        state <= S_RD_W;
                    end
                end
                S_WR_C:
                begin
                    if (en_gnt)
                    begin
                        col <= '0;
                        if (row == ROW_W'(I_ROWS - 1))
                        begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            row   <= row + 1'b1;
                            state <= S_RD_I;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == S_WAIT_I)
            i_row <= en_rdata;
        if (state == S_WAIT_W)
            c_row.lanes[col] <= scaled[ELEM_W-1:0]; // Column c lands in lane c
    end

endmodule

// ==== result_drainer.sv ====
// Reads the four C rows from the scratchpad and offers them to the output FIFO, last on row 3
`timescale 1ns/1ps

module result_drainer (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      start,
    output logic                      done,
    output logic                      dr_req,
    output logic                      dr_we,
    output logic [mm_pkg::ADDR_W-1:0] dr_addr,
    output mm_pkg::sp_word_u          dr_wdata,
    input  logic                      dr_gnt,
    input  mm_pkg::sp_word_u          dr_rdata,
    output logic [mm_pkg::WORD_W-1:0] o_data,
    output logic                      o_valid,
    input  logic                      o_ready,
    output logic                      o_last
);
    import mm_pkg::*;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_RD    = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;
    localparam logic [1:0] S_OFFER = 2'd3;

    localparam int ROW_W = $clog2(I_ROWS);

    logic [1:0]       state;
    logic [ROW_W-1:0] row;
    logic             last_row;
    sp_word_u         beat;     // Held while the FIFO is full

    assign last_row = (row == ROW_W'(I_ROWS - 1));

    assign dr_req   = (state == S_RD);
    assign dr_we    = 1'b0;     // Read-only peer
    assign dr_addr  = ADDR_W'(C_BASE) + ADDR_W'(row);
    assign dr_wdata = '0;

    assign o_valid = (state == S_OFFER);
    assign o_data  = beat.raw;
    assign o_last  = o_valid && last_row;
    assign done    = o_valid && o_ready && last_row;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state <= S_IDLE;
            row   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        state <= S_RD;
                        row   <= '0;
                    end
                end
                S_RD:   if (dr_gnt) state <= S_WAIT;
                S_WAIT: state <= S_OFFER;
                default:
                begin
                    if (o_ready)
                    begin
                        state <= last_row ? S_IDLE : S_RD;
                        row   <= row + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == S_WAIT)
            beat <= dr_rdata;
    end

endmodule

// ==== job_sequencer.sv ====
// Issues load, compute and drain start pulses so loading overlaps draining but not computing
`timescale 1ns/1ps

module job_sequencer (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic [mm_pkg::CNT_W-1:0] i_fill,
    input  logic [mm_pkg::CNT_W-1:0] w_fill,
    output logic                     load_start,
    input  logic                     load_done,
    output logic                     compute_start,
    input  logic                     compute_done,
    output logic                     drain_start,
    input  logic                     drain_done
);
    import mm_pkg::*;

    // Operand slot state
    localparam logic [1:0] OP_FREE    = 2'd0;
    localparam logic [1:0] OP_LOADING = 2'd1;
    localparam logic [1:0] OP_READY   = 2'd2;
    localparam logic [1:0] OP_BUSY    = 2'd3;  // Engine is using the operands

    logic [1:0] op_state;
    logic       drain_busy;
    logic       fills_ok;

    assign fills_ok = (i_fill >= CNT_W'(I_ROWS)) && (w_fill >= CNT_W'(W_ROWS));

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            op_state      <= OP_FREE;
            drain_busy    <= 1'b0;
            load_start    <= 1'b0;
            compute_start <= 1'b0;
            drain_start   <= 1'b0;
        end
        else
        begin
            load_start    <= 1'b0;
            compute_start <= 1'b0;
            drain_start   <= 1'b0;
            case (op_state)
                OP_FREE:
                begin
                    if (fills_ok)
                    begin
                        load_start <= 1'b1;
                        op_state   <= OP_LOADING;
                    end
                end
                OP_LOADING: if (load_done) op_state <= OP_READY;
                OP_READY:
                begin
                    if (!drain_busy) // C rows must be drained first
                    begin
                        compute_start <= 1'b1;
                        op_state      <= OP_BUSY;
                    end
                end
                default:
                begin
                    if (compute_done)
                    begin
                        drain_start <= 1'b1;
                        op_state    <= OP_FREE; // Next load may now begin
                    end
                end
            endcase
            if (compute_done)
                drain_busy <= 1'b1;
            else if (drain_done)
                drain_busy <= 1'b0;
        end
    end

endmodule

// ==== axis_matmul_top.sv ====
// Top level of the stream matrix-multiply accelerator: FIFOs, scratchpad, peers and sequencer
`timescale 1ns/1ps

module axis_matmul_top #(
    parameter int DEPTH = 8
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic [mm_pkg::WORD_W-1:0] s_axis_i_tdata,
    input  logic                      s_axis_i_tvalid,
    output logic                      s_axis_i_tready,
    input  logic [mm_pkg::WORD_W-1:0] s_axis_w_tdata,
    input  logic                      s_axis_w_tvalid,
    output logic                      s_axis_w_tready,
    output logic [mm_pkg::WORD_W-1:0] m_axis_tdata,
    output logic                      m_axis_tvalid,
    input  logic                      m_axis_tready,
    output logic                      m_axis_tlast
);
    import mm_pkg::*;

    logic [WORD_W-1:0] i_data, w_data, o_data;
    logic              i_valid, i_ready, w_valid, w_ready;
    logic              o_valid, o_ready, o_last;
    logic [CNT_W-1:0]  i_fill, w_fill;

    logic              ld_req, ld_we, ld_gnt;
    logic [ADDR_W-1:0] ld_addr;
    sp_word_u          ld_wdata;
    logic              en_req, en_we, en_gnt;
    logic [ADDR_W-1:0] en_addr;
    sp_word_u          en_wdata, en_rdata;
    logic              dr_req, dr_we, dr_gnt;
    logic [ADDR_W-1:0] dr_addr;
    sp_word_u          dr_wdata, dr_rdata;

    logic load_start, load_done, compute_start, compute_done, drain_start, drain_done;

    axis_fifo #(.DEPTH(DEPTH)) i_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .in_data(s_axis_i_tdata), .in_valid(s_axis_i_tvalid), .in_ready(s_axis_i_tready),
        .in_last(1'b0),
        .out_data(i_data), .out_valid(i_valid), .out_ready(i_ready), .out_last(),
        .fill(i_fill)
    );

    axis_fifo #(.DEPTH(DEPTH)) w_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .in_data(s_axis_w_tdata), .in_valid(s_axis_w_tvalid), .in_ready(s_axis_w_tready),
        .in_last(1'b0),
        .out_data(w_data), .out_valid(w_valid), .out_ready(w_ready), .out_last(),
        .fill(w_fill)
    );

    axis_fifo #(.DEPTH(DEPTH)) o_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .in_data(o_data), .in_valid(o_valid), .in_ready(o_ready), .in_last(o_last),
        .out_data(m_axis_tdata), .out_valid(m_axis_tvalid), .out_ready(m_axis_tready),
        .out_last(m_axis_tlast),
        .fill()
    );

    shared_scratchpad scratchpad (
        .aclk(aclk), .aresetn(aresetn),
        .ld_req(ld_req), .ld_we(ld_we), .ld_addr(ld_addr), .ld_wdata(ld_wdata),
        .ld_gnt(ld_gnt), .ld_rdata(),
        .en_req(en_req), .en_we(en_we), .en_addr(en_addr), .en_wdata(en_wdata),
        .en_gnt(en_gnt), .en_rdata(en_rdata),
        .dr_req(dr_req), .dr_we(dr_we), .dr_addr(dr_addr), .dr_wdata(dr_wdata),
        .dr_gnt(dr_gnt), .dr_rdata(dr_rdata)
    );

    operand_loader loader (
        .aclk(aclk), .aresetn(aresetn), .start(load_start), .done(load_done),
        .i_data(i_data), .i_valid(i_valid), .i_ready(i_ready),
        .w_data(w_data), .w_valid(w_valid), .w_ready(w_ready),
        .ld_req(ld_req), .ld_we(ld_we), .ld_addr(ld_addr), .ld_wdata(ld_wdata),
        .ld_gnt(ld_gnt)
    );

    dot_product_engine engine (
        .aclk(aclk), .aresetn(aresetn), .start(compute_start), .done(compute_done),
        .en_req(en_req), .en_we(en_we), .en_addr(en_addr), .en_wdata(en_wdata),
        .en_gnt(en_gnt), .en_rdata(en_rdata)
    );

    result_drainer drainer (
        .aclk(aclk), .aresetn(aresetn), .start(drain_start), .done(drain_done),
        .dr_req(dr_req), .dr_we(dr_we), .dr_addr(dr_addr), .dr_wdata(dr_wdata),
        .dr_gnt(dr_gnt), .dr_rdata(dr_rdata),
        .o_data(o_data), .o_valid(o_valid), .o_ready(o_ready), .o_last(o_last)
    );

    job_sequencer sequencer (
        .aclk(aclk), .aresetn(aresetn), .i_fill(i_fill), .w_fill(w_fill),
        .load_start(load_start), .load_done(load_done),
        .compute_start(compute_start), .compute_done(compute_done),
        .drain_start(drain_start), .drain_done(drain_done)
    );

endmodule

// ==== tb_axis_matmul.sv ====
// Random-stimulus testbench for the stream matrix-multiply accelerator, run as the simulation top
`timescale 1ns/1ps

module tb_axis_matmul;
    import mm_pkg::*;

    localparam int TOTAL_JOBS      = 27;                      // 1 + 10 + 6 + 8 + 2
    localparam int BEATS           = TOTAL_JOBS * I_ROWS;
    localparam int WATCHDOG_CYCLES = TOTAL_JOBS * 200 + 1000; // Margin covers reset and W hold

    logic              aclk            = 1'b0;
    logic              aresetn         = 1'b0;
    logic [WORD_W-1:0] s_axis_i_tdata  = '0;
    logic              s_axis_i_tvalid = 1'b0;
    logic              s_axis_i_tready;
    logic [WORD_W-1:0] s_axis_w_tdata  = '0;
    logic              s_axis_w_tvalid = 1'b0;
    logic              s_axis_w_tready;
    logic [WORD_W-1:0] m_axis_tdata;
    logic              m_axis_tvalid;
    logic              m_axis_tready   = 1'b0;
    logic              m_axis_tlast;

    // Job storage written only by the main process
    logic [WORD_W-1:0] i_rows   [BEATS];
    logic [WORD_W-1:0] w_rows   [BEATS];
    logic [WORD_W-1:0] exp_rows [BEATS];
    logic [WORD_W-1:0] cur_i    [I_ROWS];
    logic [WORD_W-1:0] cur_w    [W_ROWS];
    int                jobs_queued = 0;

    int   i_idx;        // Next I beat to put on the bus
    int   i_acc;        // I beats accepted by the DUT
    int   w_idx;
    int   w_acc;
    int   out_beats = 0;
    int   mon_errs  = 0;
    int   main_errs = 0;
    int   pass_count = 0;
    int   fail_count = 0;
    logic gaps_on    = 1'b0;
    logic rdy_random = 1'b0;
    logic w_hold     = 1'b0;

    axis_matmul_top #(.DEPTH(8)) UUT (
        .aclk(aclk), .aresetn(aresetn),
        .s_axis_i_tdata(s_axis_i_tdata), .s_axis_i_tvalid(s_axis_i_tvalid),
        .s_axis_i_tready(s_axis_i_tready),
        .s_axis_w_tdata(s_axis_w_tdata), .s_axis_w_tvalid(s_axis_w_tvalid),
        .s_axis_w_tready(s_axis_w_tready),
        .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast)
    );

    always #50 aclk = ~aclk;

    // Q8.8 dot product with a full-width sum, an arithmetic shift and the low 16 bits kept
    function automatic logic [ELEM_W-1:0] q88_dot(input logic [WORD_W-1:0] a,
                                                  input logic [WORD_W-1:0] b);
        longint sum;
        sum = 0;
        for (int k = 0; k < LANES; k++)
        begin
            sum = sum + longint'($signed(a[k*ELEM_W +: ELEM_W]))
                      * longint'($signed(b[k*ELEM_W +: ELEM_W]));
        end
        sum = sum >>> FRAC_W;
        return sum[ELEM_W-1:0];
    endfunction

    function automatic logic [WORD_W-1:0] rand_row();
        logic [WORD_W-1:0] row;
        for (int k = 0; k < LANES; k++)
        begin
            row[k*ELEM_W +: ELEM_W] = 16'($urandom);
        end
        return row;
    endfunction

    function automatic logic [WORD_W-1:0] identity_row(input int c);
        logic [WORD_W-1:0] row;
        row = '0;
        row[c*ELEM_W +: ELEM_W] = 16'h0100; // 1.0 in Q8.8
        return row;
    endfunction

    // Stores cur_i and cur_w as the next job with its expected C rows
    task automatic queue_job();
        int base;
        base = jobs_queued * I_ROWS;
        for (int r = 0; r < I_ROWS; r++)
        begin
            i_rows[base + r] = cur_i[r];
            w_rows[base + r] = cur_w[r];
            for (int c = 0; c < W_ROWS; c++)
            begin
                exp_rows[base + r][c*ELEM_W +: ELEM_W] = q88_dot(cur_i[r], cur_w[c]);
            end
        end
        jobs_queued = jobs_queued + 1;
    endtask

    task automatic wait_jobs();
        while (out_beats < jobs_queued * I_ROWS)
            @(negedge aclk);
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0)
        begin
            $display("CHECK FAILED %s during reset: expected 0, actual %h", name, value);
            main_errs = main_errs + 1;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        int errs;
        errs = mon_errs + main_errs - errs_before;
        if (errs == 0)
        begin
            pass_count = pass_count + 1;
            $display("Test %0d %s: PASS", num, name);
        end
        else
        begin
            fail_count = fail_count + 1;
            $display("Test %0d %s: FAIL with %0d errors", num, name, errs);
        end
    endtask

    // I stream driver with optional random gaps
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            s_axis_i_tvalid <= 1'b0;
            i_idx           <= 0;
            i_acc           <= 0;
        end
        else
        begin
            if (s_axis_i_tvalid && s_axis_i_tready)
                i_acc <= i_acc + 1;
            if (!s_axis_i_tvalid || s_axis_i_tready)
            begin
                if (i_idx < jobs_queued * I_ROWS && (!gaps_on || $urandom_range(0, 3) != 0))
                begin
                    s_axis_i_tdata  <= i_rows[i_idx];
                    s_axis_i_tvalid <= 1'b1;
                    i_idx           <= i_idx + 1;
                end
                else
                    s_axis_i_tvalid <= 1'b0;
            end
        end
    end

    // W stream driver that can also be held back entirely
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            s_axis_w_tvalid <= 1'b0;
            w_idx           <= 0;
            w_acc           <= 0;
        end
        else
        begin
            if (s_axis_w_tvalid && s_axis_w_tready)
                w_acc <= w_acc + 1;
            if (!s_axis_w_tvalid || s_axis_w_tready)
            begin
                if (!w_hold && w_idx < jobs_queued * W_ROWS
                    && (!gaps_on || $urandom_range(0, 3) != 0))
                begin
                    s_axis_w_tdata  <= w_rows[w_idx];
                    s_axis_w_tvalid <= 1'b1;
                    w_idx           <= w_idx + 1;
                end
                else
                    s_axis_w_tvalid <= 1'b0;
            end
        end
    end

    always @(posedge aclk)
    begin
        m_axis_tready <= rdy_random ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    task automatic check_beat();
        int job;
        int row;
        logic [WORD_W-1:0] exp_beat;
        job = out_beats / I_ROWS;
        row = out_beats % I_ROWS;
        if (out_beats >= jobs_queued * I_ROWS)
        begin
            $display("Output beat arrived with no job pending");
            mon_errs = mon_errs + 1;
        end
        else
        begin
            exp_beat = exp_rows[out_beats];
            for (int k = 0; k < LANES; k++)
            begin
                if (m_axis_tdata[k*ELEM_W +: ELEM_W] != exp_beat[k*ELEM_W +: ELEM_W])
                begin
                    $display("CHECK FAILED m_axis_tdata beat %0d lane %0d: expected %h, actual %h",
                             out_beats, k, exp_beat[k*ELEM_W +: ELEM_W],
                             m_axis_tdata[k*ELEM_W +: ELEM_W]);
                    mon_errs = mon_errs + 1;
                end
            end
        end
        if (m_axis_tlast && row != I_ROWS - 1)
        begin
            $display("Extra tlast on row %0d of job %0d", row, job);
            mon_errs = mon_errs + 1;
        end
        if (!m_axis_tlast && row == I_ROWS - 1)
        begin
            $display("Missing tlast on the last row of job %0d", job);
            mon_errs = mon_errs + 1;
        end
        if (i_acc < (job + 1) * I_ROWS || w_acc < (job + 1) * W_ROWS)
        begin
            $display("Output of job %0d appeared before all its operand beats were sent", job);
            mon_errs = mon_errs + 1;
        end
        out_beats = out_beats + 1;
    endtask

    always @(posedge aclk)
    begin
        if (aresetn && m_axis_tvalid && m_axis_tready)
            check_beat();
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles with %0d of %0d output beats seen",
                 WATCHDOG_CYCLES, out_beats, jobs_queued * I_ROWS);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        int errs_before;
        int beats_before;
        void'($urandom(32'h4e4d));
        errs_before = mon_errs + main_errs;
        repeat (7) @(posedge aclk);
        @(negedge aclk);
        expect_low("m_axis_tvalid", m_axis_tvalid); // Stream handshakes idle in reset
        expect_low("s_axis_i_tready", s_axis_i_tready);
        expect_low("s_axis_w_tready", s_axis_w_tready);
        @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);

        for (int r = 0; r < I_ROWS; r++)
        begin
            cur_i[r] = rand_row();
            cur_w[r] = identity_row(r);
        end
        queue_job();
        wait_jobs();
        finish_test(1, "identity weights", errs_before);

        errs_before = mon_errs + main_errs;
        gaps_on = 1'b1;
        for (int j = 0; j < 10; j++)
        begin
            for (int r = 0; r < I_ROWS; r++)
            begin
                cur_i[r] = rand_row();
                cur_w[r] = rand_row();
            end
            queue_job();
        end
        wait_jobs();
        finish_test(2, "random signed matrices", errs_before);

        // Reuses the operands of the first six random jobs under output stalls
        errs_before = mon_errs + main_errs;
        rdy_random = 1'b1;
        for (int j = 1; j <= 6; j++)
        begin
            for (int r = 0; r < I_ROWS; r++)
            begin
                cur_i[r] = i_rows[j * I_ROWS + r];
                cur_w[r] = w_rows[j * I_ROWS + r];
            end
            queue_job();
        end
        wait_jobs();
        rdy_random = 1'b0;
        finish_test(3, "output back-pressure", errs_before);

        errs_before = mon_errs + main_errs;
        gaps_on = 1'b0;   // Dense input so loads overlap drains
        for (int j = 0; j < 8; j++)
        begin
            for (int r = 0; r < I_ROWS; r++)
            begin
                cur_i[r] = rand_row();
                cur_w[r] = rand_row();
            end
            queue_job();
        end
        wait_jobs();
        finish_test(4, "back-to-back jobs", errs_before);

        errs_before = mon_errs + main_errs;
        gaps_on = 1'b1;
        w_hold  = 1'b1;
        beats_before = out_beats;
        for (int j = 0; j < 2; j++)
        begin
            for (int r = 0; r < I_ROWS; r++)
            begin
                cur_i[r] = rand_row();
                cur_w[r] = rand_row();
            end
            queue_job();
        end
        repeat (80) @(negedge aclk);
        if (out_beats != beats_before)
        begin
            $display("Output appeared while the weight stream was still held back");
            main_errs = main_errs + 1;
        end
        w_hold = 1'b0;
        wait_jobs();
        finish_test(5, "delayed weight stream", errs_before);

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && mon_errs + main_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== sim.f ====
mm_pkg.sv
axis_fifo.sv
shared_scratchpad.sv
operand_loader.sv
dot_product_engine.sv
result_drainer.sv
job_sequencer.sv
axis_matmul_top.sv
tb_axis_matmul.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_axis_matmul -f sim.f -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_axis_matmul > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
